// File: src/exu_pkg.sv
package exu_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////

   // general register width, one word
   localparam int GRLEN      = 32;
   // register file index
   localparam int REG_IDX_W  = 5;
   // csr address space
   localparam int CSR_ADDR_W = 14;

   //////////////////////////////////////////////////////////////////////
   // vector types
   //////////////////////////////////////////////////////////////////////

   // register value, operand or result
   typedef logic [GRLEN-1:0]      gr_t;
   // register file index
   typedef logic [REG_IDX_W-1:0]  reg_idx_t;
   // csr address
   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // csrwr is a csrxchg whose mask covers the whole register
   localparam gr_t CSR_FULL_MASK = '1;

   //////////////////////////////////////////////////////////////////////
   // lsu outstanding tracker
   //////////////////////////////////////////////////////////////////////

   // idle until an lsu op leaves e, busy until its finish at m
   typedef enum logic {
      LSU_IDLE = 1'b0,
      LSU_BUSY = 1'b1
   } lsu_state_t;

endpackage

// File: src/exu_bypass.sv
`timescale 1ns/1ps

module exu_bypass (
   // source indices at e
   input  exu_pkg::reg_idx_t rs1_e,
   input  exu_pkg::reg_idx_t rs2_e,
   // register file values (b may already hold the immediate)
   input  exu_pkg::gr_t      alu_a_e,
   input  exu_pkg::gr_t      alu_b_e,
   input  exu_pkg::gr_t      imm_shifted_e,
   input  logic              alu_b_imm_e,
   input  logic              double_read_e,
   // m stage producer
   input  exu_pkg::reg_idx_t rd_m,
   input  logic              wen_m,
   input  exu_pkg::gr_t      rd_data_m,
   // w stage producer
   input  exu_pkg::reg_idx_t irf_rd_w,
   input  logic              irf_wen_w,
   input  exu_pkg::gr_t      irf_rd_data_w,
   // forwarded operands
   output exu_pkg::gr_t      operand_a,
   output exu_pkg::gr_t      operand_b,
   output exu_pkg::gr_t      lsu_offset_e
);

   logic rs1_hit_m;
   logic rs1_hit_w;
   logic rs2_hit_m;
   logic rs2_hit_w;
   logic rs2_use_other;

   // index match against each producer, r0 included
   assign rs1_hit_m = wen_m & (rs1_e == rd_m);
   assign rs1_hit_w = irf_wen_w & (rs1_e == irf_rd_w);

   // b takes no forwarding for an immediate or a double read
   assign rs2_use_other = alu_b_imm_e | double_read_e;
   assign rs2_hit_m     = ~rs2_use_other & wen_m & (rs2_e == rd_m);
   assign rs2_hit_w     = ~rs2_use_other & irf_wen_w & (rs2_e == irf_rd_w);

   // operand a, youngest producer first
   always_comb begin
      if (rs1_hit_m) begin
         operand_a = rd_data_m;
      end else if (rs1_hit_w) begin
         operand_a = irf_rd_data_w;
      end else begin
         operand_a = alu_a_e;
      end
   end

   // operand b, same priority
   always_comb begin
      if (rs2_hit_m) begin
         operand_b = rd_data_m;
      end else if (rs2_hit_w) begin
         operand_b = irf_rd_data_w;
      end else begin
         operand_b = alu_b_e;
      end
   end

   // register offset for double reads, immediate otherwise
   assign lsu_offset_e = double_read_e ? operand_b : imm_shifted_e;

endmodule

// File: src/exu_writeback.sv
`timescale 1ns/1ps

module exu_writeback (
   input  logic              clk,
   input  logic              rst_n,
   // alu result and target at e
   input  exu_pkg::gr_t      alu_res_e,
   input  exu_pkg::reg_idx_t rf_target_e,
   input  logic              alu_wen_ok_e,
   // csr read path
   input  logic              csr_go_e,
   input  logic              csr_rdwen_e,
   input  exu_pkg::gr_t      csr_rdata_m,
   // lsu return at m
   input  exu_pkg::gr_t      lsu_rdata_m,
   input  logic              lsu_finish_m,
   input  logic              lsu_wen_m,
   input  exu_pkg::reg_idx_t lsu_rd_m,
   // m stage view for forwarding
   output exu_pkg::reg_idx_t rd_m,
   output logic              wen_m,
   output exu_pkg::gr_t      rd_data_m,
   // register file write port
   output exu_pkg::reg_idx_t irf_rd_w,
   output logic              irf_wen_w,
   output exu_pkg::gr_t      irf_rd_data_w
);

   import exu_pkg::*;

   gr_t      alu_res_m;
   reg_idx_t rf_target_m;
   logic     alu_wen_m;
   logic     csr_valid_m;
   logic     csr_rdwen_m;

   //////////////////////////////////////////////////////////////////////
   // e to m
   //////////////////////////////////////////////////////////////////////

   // write claims
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_m   <= 1'b0;
         csr_valid_m <= 1'b0;
         csr_rdwen_m <= 1'b0;
      end else begin
         alu_wen_m   <= alu_wen_ok_e;
         csr_valid_m <= csr_go_e;
         csr_rdwen_m <= csr_rdwen_e;
      end
   end

   // result and target, csr read shares the alu target
   always_ff @(posedge clk) begin
      alu_res_m   <= alu_res_e;
      rf_target_m <= rf_target_e;
   end

   //////////////////////////////////////////////////////////////////////
   // m stage select
   //////////////////////////////////////////////////////////////////////

   // lsu finish wins, then csr read, alu by default
   always_comb begin
      if (lsu_finish_m) begin
         rd_data_m = lsu_rdata_m;
      end else if (csr_valid_m) begin
         rd_data_m = csr_rdata_m;
      end else begin
         rd_data_m = alu_res_m;
      end
   end

   // lsu keeps its own rd since its latency varies
   assign rd_m  = lsu_finish_m ? lsu_rd_m : rf_target_m;

   // any unit may claim the write
   assign wen_m = alu_wen_m | (lsu_wen_m & lsu_finish_m) | csr_rdwen_m;

   //////////////////////////////////////////////////////////////////////
   // m to w
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         irf_wen_w <= 1'b0;
      end else begin
         irf_wen_w <= wen_m;
      end
   end

   always_ff @(posedge clk) begin
      irf_rd_w      <= rd_m;
      irf_rd_data_w <= rd_data_m;
   end

endmodule

// File: src/exu_csr_stage.sv
`timescale 1ns/1ps

module exu_csr_stage (
   input  logic               clk,
   input  logic               rst_n,
   // csr read data, one cycle ahead of e
   input  exu_pkg::gr_t       csr_rdata_d,
   // forwarded operands, a is the mask and b the data
   input  exu_pkg::gr_t       operand_a,
   input  exu_pkg::gr_t       operand_b,
   input  logic               csr_xchg_e,
   input  logic               csr_wen_e,
   input  exu_pkg::csr_addr_t csr_waddr_e,
   // read data at m for writeback
   output exu_pkg::gr_t       csr_rdata_m,
   // csr write port
   output logic               csr_wen_m,
   output exu_pkg::csr_addr_t csr_waddr_m,
   output exu_pkg::gr_t       csr_wdata_m,
   output exu_pkg::gr_t       csr_mask_m
);

   import exu_pkg::*;

   gr_t csr_rdata_e;
   gr_t csr_mask_e;

   //////////////////////////////////////////////////////////////////////
   // read data, d to e to m
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      csr_rdata_e <= csr_rdata_d;
      csr_rdata_m <= csr_rdata_e;
   end

   //////////////////////////////////////////////////////////////////////
   // write staging
   //////////////////////////////////////////////////////////////////////

   // csrxchg masks with rj, csrwr writes every bit
   assign csr_mask_e = csr_xchg_e ? operand_a : CSR_FULL_MASK;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_wen_m <= 1'b0;
      end else begin
         csr_wen_m <= csr_wen_e;
      end
   end

   // write address equals the read address of the same instruction
   always_ff @(posedge clk) begin
      csr_waddr_m <= csr_waddr_e;
      csr_wdata_m <= operand_b;
      csr_mask_m  <= csr_mask_e;
   end

endmodule

// File: src/exu_ctrl.sv
`timescale 1ns/1ps

module exu_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic valid_e,
   input  logic timer_intr,
   // raw requests from decode
   input  logic lsu_valid_e,
   input  logic alu_wen_e,
   input  logic csr_valid_e,
   // lsu status
   input  logic lsu_finish_m,
   input  logic lsu_ale_e,
   input  logic illinst_e,
   // csr write progress
   input  logic csr_wen_e,
   input  logic csr_wen_m,
   // gated requests
   output logic lsu_go_e,
   output logic alu_wen_ok_e,
   output logic csr_go_e,
   output logic except,
   output logic stall_req
);

   import exu_pkg::*;

   logic       intr;
   logic       kill_e;
   logic       intr_hold_q;
   lsu_state_t lsu_state_q;
   lsu_state_t lsu_state_next;
   logic       csr_stall_q;
   logic       csr_stall_next;

   //////////////////////////////////////////////////////////////////////
   // interrupt hold
   //////////////////////////////////////////////////////////////////////

   // interrupt waits for a valid instruction at e
   // bubbles at e keep it pending in the hold flag
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         intr_hold_q <= 1'b0;
      end else if (timer_intr | valid_e) begin
         intr_hold_q <= timer_intr & ~valid_e;
      end
   end

   assign intr = valid_e & (timer_intr | intr_hold_q);

   // only the interrupt kills e
   // ale comes from the lsu at e and would loop back through lsu_go_e
   assign kill_e = intr;

   assign lsu_go_e     = lsu_valid_e & ~kill_e;
   assign alu_wen_ok_e = alu_wen_e & ~kill_e;
   assign csr_go_e     = csr_valid_e & ~kill_e;

   // misaligned access, illegal instruction or interrupt
   assign except = lsu_ale_e | illinst_e | intr;

   //////////////////////////////////////////////////////////////////////
   // stall tracking
   //////////////////////////////////////////////////////////////////////

   // busy from the cycle after go until the cycle after finish
   always_comb begin
      lsu_state_next = lsu_state_q;
      if (lsu_go_e) begin
         lsu_state_next = LSU_BUSY;
      end else if (lsu_finish_m) begin
         lsu_state_next = LSU_IDLE;
      end
   end

   // csr write holds fetch until it lands at m
   assign csr_stall_next = csr_wen_e | (csr_stall_q & ~csr_wen_m);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lsu_state_q <= LSU_IDLE;
         csr_stall_q <= 1'b0;
      end else begin
         lsu_state_q <= lsu_state_next;
         csr_stall_q <= csr_stall_next;
      end
   end

   assign stall_req = lsu_go_e | (lsu_state_q == LSU_BUSY) | csr_stall_next;

endmodule

// File: src/exu_ecl.sv
`timescale 1ns/1ps

module exu_ecl (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               valid_e,
   input  logic               timer_intr,
   // alu
   input  exu_pkg::gr_t       alu_a_e,
   input  exu_pkg::gr_t       alu_b_e,
   input  logic               alu_b_imm_e,
   input  exu_pkg::reg_idx_t  rs1_e,
   input  exu_pkg::reg_idx_t  rs2_e,
   input  exu_pkg::reg_idx_t  rf_target_e,
   input  logic               alu_wen_e,
   input  exu_pkg::gr_t       alu_res_e,
   input  logic               illinst_e,
   // lsu
   input  logic               lsu_valid_e,
   input  logic               double_read_e,
   input  exu_pkg::gr_t       imm_shifted_e,
   input  exu_pkg::gr_t       lsu_rdata_m,
   input  logic               lsu_finish_m,
   input  exu_pkg::reg_idx_t  lsu_rd_m,
   input  logic               lsu_wen_m,
   input  logic               lsu_ale_e,
   // csr
   input  logic               csr_valid_e,
   input  exu_pkg::gr_t       csr_rdata_d,
   input  logic               csr_rdwen_e,
   input  logic               csr_xchg_e,
   input  logic               csr_wen_e,
   input  exu_pkg::csr_addr_t csr_waddr_e,
   // forwarded operands, base and branch a, alu b and store data
   output exu_pkg::gr_t       operand_a,
   output exu_pkg::gr_t       operand_b,
   output logic               lsu_go_e,
   output exu_pkg::gr_t       lsu_offset_e,
   // csr write port
   output logic               csr_wen_m,
   output exu_pkg::csr_addr_t csr_waddr_m,
   output exu_pkg::gr_t       csr_wdata_m,
   output exu_pkg::gr_t       csr_mask_m,
   // to fetch
   output logic               except,
   output logic               stall_req,
   // register file write port
   output exu_pkg::gr_t       irf_rd_data_w,
   output logic               irf_wen_w,
   output exu_pkg::reg_idx_t  irf_rd_w
);

   import exu_pkg::*;

   // kill gated requests
   logic     alu_wen_ok_e;
   logic     csr_go_e;
   // m stage producer
   reg_idx_t rd_m;
   logic     wen_m;
   gr_t      rd_data_m;
   gr_t      csr_rdata_m;

   exu_ctrl u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .valid_e      (valid_e),
      .timer_intr   (timer_intr),
      .lsu_valid_e  (lsu_valid_e),
      .alu_wen_e    (alu_wen_e),
      .csr_valid_e  (csr_valid_e),
      .lsu_finish_m (lsu_finish_m),
      .lsu_ale_e    (lsu_ale_e),
      .illinst_e    (illinst_e),
      .csr_wen_e    (csr_wen_e),
      .csr_wen_m    (csr_wen_m),
      .lsu_go_e     (lsu_go_e),
      .alu_wen_ok_e (alu_wen_ok_e),
      .csr_go_e     (csr_go_e),
      .except       (except),
      .stall_req    (stall_req)
   );

   exu_bypass u_bypass (
      .rs1_e         (rs1_e),
      .rs2_e         (rs2_e),
      .alu_a_e       (alu_a_e),
      .alu_b_e       (alu_b_e),
      .imm_shifted_e (imm_shifted_e),
      .alu_b_imm_e   (alu_b_imm_e),
      .double_read_e (double_read_e),
      .rd_m          (rd_m),
      .wen_m         (wen_m),
      .rd_data_m     (rd_data_m),
      .irf_rd_w      (irf_rd_w),
      .irf_wen_w     (irf_wen_w),
      .irf_rd_data_w (irf_rd_data_w),
      .operand_a     (operand_a),
      .operand_b     (operand_b),
      .lsu_offset_e  (lsu_offset_e)
   );

   exu_writeback u_writeback (
      .clk           (clk),
      .rst_n         (rst_n),
      .alu_res_e     (alu_res_e),
      .rf_target_e   (rf_target_e),
      .alu_wen_ok_e  (alu_wen_ok_e),
      .csr_go_e      (csr_go_e),
      .csr_rdwen_e   (csr_rdwen_e),
      .csr_rdata_m   (csr_rdata_m),
      .lsu_rdata_m   (lsu_rdata_m),
      .lsu_finish_m  (lsu_finish_m),
      .lsu_wen_m     (lsu_wen_m),
      .lsu_rd_m      (lsu_rd_m),
      .rd_m          (rd_m),
      .wen_m         (wen_m),
      .rd_data_m     (rd_data_m),
      .irf_rd_w      (irf_rd_w),
      .irf_wen_w     (irf_wen_w),
      .irf_rd_data_w (irf_rd_data_w)
   );

   exu_csr_stage u_csr (
      .clk         (clk),
      .rst_n       (rst_n),
      .csr_rdata_d (csr_rdata_d),
      .operand_a   (operand_a),
      .operand_b   (operand_b),
      .csr_xchg_e  (csr_xchg_e),
      .csr_wen_e   (csr_wen_e),
      .csr_waddr_e (csr_waddr_e),
      .csr_rdata_m (csr_rdata_m),
      .csr_wen_m   (csr_wen_m),
      .csr_waddr_m (csr_waddr_m),
      .csr_wdata_m (csr_wdata_m),
      .csr_mask_m  (csr_mask_m)
   );

endmodule

// File: tests/tb_exu_model.svh
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// shadow pipeline state
//////////////////////////////////////////////////////////////////////

// control flags
logic      hold_s;
logic      lsu_busy_s;
logic      csr_stall_s;
// e to m registers
gr_t       alu_res_s;
reg_idx_t  target_s;
logic      alu_wen_s;
logic      csr_valid_s;
logic      csr_rdwen_s;
// csr read data, d to e to m
gr_t       csr_rd_e_s;
gr_t       csr_rd_m_s;
// register file write port
reg_idx_t  w_rd_s;
logic      w_wen_s;
gr_t       w_data_s;
// csr write port
logic      cw_wen_s;
csr_addr_t cw_addr_s;
gr_t       cw_data_s;
gr_t       cw_mask_s;

// expected values in the current cycle
logic      exp_intr;
logic      exp_lsu_go;
logic      exp_except;
logic      exp_stall;
logic      exp_csr_stall_next;
reg_idx_t  exp_rd_m;
logic      exp_wen_m;
gr_t       exp_data_m;
gr_t       exp_opa;
gr_t       exp_opb;
gr_t       exp_offset;

task automatic clear_shadow();
   {hold_s, lsu_busy_s, csr_stall_s} = '0;
   {alu_wen_s, csr_valid_s, csr_rdwen_s, w_wen_s, cw_wen_s} = '0;
   alu_res_s  = '0;
   target_s   = '0;
   csr_rd_e_s = '0;
   csr_rd_m_s = '0;
   w_rd_s     = '0;
   w_data_s   = '0;
   cw_addr_s  = '0;
   cw_data_s  = '0;
   cw_mask_s  = '0;
endtask

// youngest producer wins: m, then w, then register file
function automatic gr_t forward_value(input reg_idx_t idx, input gr_t rf_val);
   if (exp_wen_m && idx == exp_rd_m) return exp_data_m;
   if (w_wen_s && idx == w_rd_s) return w_data_s;
   return rf_val;
endfunction

task automatic predict_outputs();
   // pending or fresh timer interrupt takes the valid instruction
   exp_intr   = valid_e & (timer_intr | hold_s);
   exp_lsu_go = lsu_valid_e & ~exp_intr;
   exp_except = lsu_ale_e | illinst_e | exp_intr;
   // m stage: lsu finish first, then csr read, then alu
   exp_wen_m  = alu_wen_s | csr_rdwen_s | (lsu_finish_m & lsu_wen_m);
   exp_rd_m   = lsu_finish_m ? lsu_rd_m : target_s;
   if (lsu_finish_m) exp_data_m = lsu_rdata_m;
   else if (csr_valid_s) exp_data_m = csr_rd_m_s;
   else exp_data_m = alu_res_s;
   exp_opa    = forward_value(rs1_e, alu_a_e);
   // immediate or double read bypasses forwarding on b
   exp_opb    = (alu_b_imm_e | double_read_e) ? alu_b_e : forward_value(rs2_e, alu_b_e);
   exp_offset = double_read_e ? exp_opb : imm_shifted_e;
   exp_csr_stall_next = csr_wen_e | (csr_stall_s & ~cw_wen_s);
   exp_stall  = exp_lsu_go | lsu_busy_s | exp_csr_stall_next;
endtask

// clock edge at the end of the current cycle
task automatic advance_stages();
   w_wen_s    = rst_n & exp_wen_m;
   w_rd_s     = exp_rd_m;
   w_data_s   = exp_data_m;
   cw_wen_s   = rst_n & csr_wen_e;
   cw_addr_s  = csr_waddr_e;
   cw_data_s  = exp_opb;
   cw_mask_s  = csr_xchg_e ? exp_opa : '1;
   csr_rd_m_s = csr_rd_e_s;
   csr_rd_e_s = csr_rdata_d;
   alu_res_s  = alu_res_e;
   target_s   = rf_target_e;
   if (!rst_n) begin
      {hold_s, lsu_busy_s, csr_stall_s} = '0;
      {alu_wen_s, csr_valid_s, csr_rdwen_s} = '0;
   end else begin
      alu_wen_s   = alu_wen_e & ~exp_intr;
      csr_valid_s = csr_valid_e & ~exp_intr;
      csr_rdwen_s = csr_rdwen_e;
      if (timer_intr | valid_e) hold_s = timer_intr & ~valid_e;
      if (exp_lsu_go) lsu_busy_s = 1'b1;
      else if (lsu_finish_m) lsu_busy_s = 1'b0;
      csr_stall_s = exp_csr_stall_next;
   end
endtask

`endif

// File: tests/tb_exu_ecl.sv
`timescale 1ns/1ps

module tb_exu_ecl;

   import exu_pkg::*;

   localparam int RESET_CYCLES   = 8;
   localparam int RANDOM_CYCLES  = 2000;
   localparam int DRAIN_CYCLES   = 10;
   // whole run plus margin
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES + 82;

   logic clk;
   logic rst_n;
   logic valid_e, timer_intr, alu_b_imm_e, alu_wen_e, illinst_e;
   logic lsu_valid_e, double_read_e, lsu_finish_m, lsu_wen_m, lsu_ale_e;
   logic csr_valid_e, csr_rdwen_e, csr_xchg_e, csr_wen_e;
   gr_t alu_a_e, alu_b_e, alu_res_e, imm_shifted_e, lsu_rdata_m, csr_rdata_d;
   reg_idx_t rs1_e, rs2_e, rf_target_e, lsu_rd_m;
   csr_addr_t csr_waddr_e;
   // dut outputs
   gr_t operand_a, operand_b, lsu_offset_e, csr_wdata_m, csr_mask_m, irf_rd_data_w;
   logic lsu_go_e, csr_wen_m, except, stall_req, irf_wen_w;
   csr_addr_t csr_waddr_m;
   reg_idx_t irf_rd_w;

   // environment state
   logic [31:0] rng;
   int          lsu_wait;
   logic        stall_seen;
   int          mismatches;
   int          failures;

   `include "tb_exu_model.svh"

   exu_ecl dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic draw_word(output logic [31:0] word);
      rng  = xorshift32(rng);
      word = rng;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      mismatches++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
   endtask

   task automatic report_failure(input string what);
      failures++;
      $display("ERROR %s at %0t", what, $time);
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic drive_inputs(input logic issue);
      logic [31:0] ctl;
      logic [31:0] idx;
      logic        is_lsu;
      logic        is_csr;
      draw_word(ctl);
      draw_word(idx);
      // no new instruction while fetch is stalled
      valid_e       = issue & (ctl[1:0] != 2'b00);
      timer_intr    = (ctl[6:3] == 4'h0);
      is_lsu        = valid_e & ctl[7] & ctl[8];
      is_csr        = valid_e & ~is_lsu & (ctl[11:9] == 3'b000);
      lsu_valid_e   = is_lsu;
      lsu_ale_e     = is_lsu & (ctl[15:12] == 4'h0);
      double_read_e = ctl[16] & ctl[17];
      alu_b_imm_e   = ctl[18];
      alu_wen_e     = valid_e & ~is_lsu & ~is_csr & (ctl[20:19] != 2'b00);
      illinst_e     = valid_e & (ctl[25:21] == 5'h00);
      csr_valid_e   = is_csr;
      csr_rdwen_e   = is_csr & ctl[26];
      csr_wen_e     = is_csr & ctl[27];
      csr_xchg_e    = ctl[28];
      // few indices so forwarding hits often
      rs1_e       = {2'b00, idx[2:0]};
      rs2_e       = {2'b00, idx[5:3]};
      rf_target_e = {2'b00, idx[8:6]};
      lsu_rd_m    = {2'b00, idx[11:9]};
      csr_waddr_e = idx[31:18];
      draw_word(alu_a_e);
      draw_word(alu_b_e);
      draw_word(alu_res_e);
      draw_word(imm_shifted_e);
      draw_word(csr_rdata_d);
      draw_word(lsu_rdata_m);
      // lsu responder gives one finish per operation
      lsu_finish_m = 1'b0;
      lsu_wen_m    = 1'b0;
      if (lsu_wait > 0) begin
         lsu_wait = lsu_wait - 1;
         if (lsu_wait == 0) begin
            lsu_finish_m = 1'b1;
            lsu_wen_m    = idx[12] | idx[13];
         end
      end
   endtask

   // finish comes 1 to 4 cycles after go
   task automatic respond_lsu();
      logic [31:0] r;
      if (lsu_go_e) begin
         if (lsu_wait != 0)
            report_failure("lsu operation issued while another is outstanding");
         draw_word(r);
         lsu_wait = 1 + int'(r[1:0]);
      end
   endtask

   task automatic check_outputs();
      if (operand_a !== exp_opa) report_mismatch("operand_a", operand_a, exp_opa);
      if (operand_b !== exp_opb) report_mismatch("operand_b", operand_b, exp_opb);
      if (lsu_offset_e !== exp_offset)
         report_mismatch("lsu_offset_e", lsu_offset_e, exp_offset);
      if (lsu_go_e !== exp_lsu_go)
         report_mismatch("lsu_go_e", 32'(lsu_go_e), 32'(exp_lsu_go));
      if (except !== exp_except) report_mismatch("except", 32'(except), 32'(exp_except));
      if (stall_req !== exp_stall)
         report_mismatch("stall_req", 32'(stall_req), 32'(exp_stall));
      if (irf_wen_w !== w_wen_s) report_mismatch("irf_wen_w", 32'(irf_wen_w), 32'(w_wen_s));
      if (w_wen_s && irf_rd_w !== w_rd_s)
         report_mismatch("irf_rd_w", 32'(irf_rd_w), 32'(w_rd_s));
      if (w_wen_s && irf_rd_data_w !== w_data_s)
         report_mismatch("irf_rd_data_w", irf_rd_data_w, w_data_s);
      if (csr_wen_m !== cw_wen_s) report_mismatch("csr_wen_m", 32'(csr_wen_m), 32'(cw_wen_s));
      if (cw_wen_s && csr_waddr_m !== cw_addr_s)
         report_mismatch("csr_waddr_m", 32'(csr_waddr_m), 32'(cw_addr_s));
      if (cw_wen_s && csr_wdata_m !== cw_data_s)
         report_mismatch("csr_wdata_m", csr_wdata_m, cw_data_s);
      if (cw_wen_s && csr_mask_m !== cw_mask_s)
         report_mismatch("csr_mask_m", csr_mask_m, cw_mask_s);
   endtask

   // drive after the edge, check mid cycle, then step the model
   task automatic run_cycle(input logic active, input logic checked);
      @(posedge clk);
      #1;
      if (checked) rst_n = 1'b1;
      if (checked) drive_inputs(active & ~stall_seen);
      @(negedge clk);
      predict_outputs();
      if (checked) check_outputs();
      if (checked) respond_lsu();
      stall_seen = stall_req;
      advance_stages();
   endtask

   initial begin : stimulus
      rst_n = 1'b0;
      {valid_e, timer_intr, alu_b_imm_e, alu_wen_e, illinst_e} = '0;
      {lsu_valid_e, double_read_e, lsu_finish_m, lsu_wen_m, lsu_ale_e} = '0;
      {csr_valid_e, csr_rdwen_e, csr_xchg_e, csr_wen_e} = '0;
      {alu_a_e, alu_b_e, alu_res_e, imm_shifted_e, lsu_rdata_m, csr_rdata_d} = '0;
      {rs1_e, rs2_e, rf_target_e, lsu_rd_m, csr_waddr_e} = '0;
      rng        = 32'h2426;
      lsu_wait   = 0;
      stall_seen = 1'b0;
      mismatches = 0;
      failures   = 0;
      clear_shadow();
      repeat (RESET_CYCLES) run_cycle(1'b0, 1'b0);
      repeat (RANDOM_CYCLES) run_cycle(1'b1, 1'b1);
      // let outstanding lsu and csr work retire
      repeat (DRAIN_CYCLES) run_cycle(1'b0, 1'b1);
      if (stall_req !== 1'b0) report_failure("stall request still high after drain");
      $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: all.f
+incdir+tests
src/exu_pkg.sv
src/exu_bypass.sv
src/exu_writeback.sv
src/exu_csr_stage.sv
src/exu_ctrl.sv
src/exu_ecl.sv
tests/tb_exu_ecl.sv

// File: Makefile
SIM := obj_dir/Vtb_exu_ecl

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

$(SIM): all.f $(wildcard src/*.sv tests/*.sv tests/*.svh)
	verilator --binary -j 0 --top-module tb_exu_ecl -f all.f

clean:
	rm -rf obj_dir sim.log
